//--- verilog/isa_pkg.sv
package isa_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    typedef enum logic [7:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,  // signed compare
        alu_sll,
        alu_lui,
        alu_nop
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_j
    } br_kind_t;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;

    // funct codes under op_special, instr[5:0]
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

endpackage

//--- verilog/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic                  valid;
        logic [data_w-1:0]     pc;
        alu_op_t               alu_op;
        br_kind_t              br_kind;
        logic [data_w-1:0]     opr1;
        logic [data_w-1:0]     opr2;
        logic [data_w-1:0]     offset;  // sign-extended branch offset or raw jump index
        logic [reg_addr_w-1:0] wraddr;
        logic                  wreg;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [data_w-1:0]     pc;
        logic [data_w-1:0]     result;
        logic [reg_addr_w-1:0] wraddr;
        logic                  wreg;
    } ex_wb_t;

    localparam id_ex_t id_ex_bubble = '{
        valid: 1'b0, pc: '0, alu_op: alu_nop, br_kind: br_none,
        opr1: '0, opr2: '0, offset: '0, wraddr: '0, wreg: 1'b0
    };

    localparam ex_wb_t ex_wb_bubble = '{
        valid: 1'b0, pc: '0, result: '0, wraddr: '0, wreg: 1'b0
    };

endpackage

//--- verilog/fetch_wb.sv
`timescale 1ns/1ps

module fetch_wb #(
    parameter logic [isa_pkg::data_w-1:0] reset_pc = '0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  logic                       redirect,
    input  logic [isa_pkg::data_w-1:0] redirect_pc,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic [isa_pkg::data_w-3:0] wb_adr,
    input  logic [isa_pkg::data_w-1:0] wb_dat_i,
    input  logic                       wb_ack,
    output logic                       id_valid,
    output logic [isa_pkg::data_w-1:0] id_pc,
    output logic [isa_pkg::data_w-1:0] id_instr
);
    import isa_pkg::*;

    logic [data_w-1:0] pc;      // byte address of the next word to read
    logic [data_w-3:0] adr;     // word address of the open cycle
    logic              stale;   // the open cycle was overtaken by a redirect
    logic              consume;
    logic              take;

    assign consume = id_valid && !stall;
    assign take    = wb_cyc && wb_ack && !stale && !redirect;

    assign wb_stb = wb_cyc;
    assign wb_adr = adr;  // stays put until ack, even across a redirect

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= reset_pc;
            adr      <= reset_pc[data_w-1:2];
            wb_cyc   <= 1'b0;
            stale    <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            if (wb_cyc && wb_ack) begin
                wb_cyc <= 1'b0;
                stale  <= 1'b0;
            end else if (!wb_cyc && (!id_valid || consume) && !redirect) begin
                wb_cyc <= 1'b1;  // holding slot is free by the next edge
                adr    <= pc[data_w-1:2];
            end

            if (take) begin
                id_valid <= 1'b1;
                pc       <= pc + data_w'(4);
            end else if (consume) begin
                id_valid <= 1'b0;
            end

            // the wrong-path word in ID is dropped and fetching restarts at the target
            if (redirect) begin
                pc       <= redirect_pc;
                id_valid <= 1'b0;
                if (wb_cyc && !wb_ack)
                    stale <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            id_pc    <= pc;
            id_instr <= wb_dat_i;
        end
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [isa_pkg::reg_addr_w-1:0] ra1,
    input  logic [isa_pkg::reg_addr_w-1:0] ra2,
    input  logic                           we,
    input  logic [isa_pkg::reg_addr_w-1:0] wa,
    input  logic [isa_pkg::data_w-1:0]     wd,
    output logic [isa_pkg::data_w-1:0]     rd1,
    output logic [isa_pkg::data_w-1:0]     rd2
);
    import isa_pkg::*;

    logic [data_w-1:0] regs [1:(1 << reg_addr_w) - 1];  // no storage for register 0

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < (1 << reg_addr_w); i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // a write in the same cycle shows through to the reader
    assign rd1 = (ra1 == '0)          ? '0 :
                 (we && wa == ra1)    ? wd : regs[ra1];
    assign rd2 = (ra2 == '0)          ? '0 :
                 (we && wa == ra2)    ? wd : regs[ra2];

endmodule

//--- verilog/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic                           id_valid,
    input  logic [isa_pkg::data_w-1:0]     id_pc,
    input  logic [isa_pkg::data_w-1:0]     id_instr,
    input  logic [isa_pkg::data_w-1:0]     rd1,
    input  logic [isa_pkg::data_w-1:0]     rd2,
    input  logic                           fwd_wreg,
    input  logic [isa_pkg::reg_addr_w-1:0] fwd_wraddr,
    input  logic [isa_pkg::data_w-1:0]     fwd_data,
    output logic [isa_pkg::reg_addr_w-1:0] ra1,
    output logic [isa_pkg::reg_addr_w-1:0] ra2,
    output pipe_pkg::id_ex_t               id_ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [4:0]            shamt;
    logic [data_w-1:0]     src_s;
    logic [data_w-1:0]     src_t;
    logic [data_w-1:0]     imm_sext;
    logic [data_w-1:0]     imm_zext;
    logic                  known;
    id_ex_t                p;

    assign opcode   = id_instr[31:26];
    assign rs       = id_instr[25:21];
    assign rt       = id_instr[20:16];
    assign rd       = id_instr[15:11];
    assign shamt    = id_instr[10:6];
    assign funct    = id_instr[5:0];
    assign imm_sext = {{(data_w-16){id_instr[15]}}, id_instr[15:0]};
    assign imm_zext = {{(data_w-16){1'b0}}, id_instr[15:0]};

    assign ra1 = rs;
    assign ra2 = rt;

    // the instruction in EX is younger than anything in the register file
    assign src_s = (fwd_wreg && rs != '0 && fwd_wraddr == rs) ? fwd_data : rd1;
    assign src_t = (fwd_wreg && rt != '0 && fwd_wraddr == rt) ? fwd_data : rd2;

    always_comb begin
        p        = id_ex_bubble;
        known    = 1'b1;
        p.valid  = 1'b1;
        p.pc     = id_pc;
        p.opr1   = src_s;
        p.opr2   = src_t;
        p.offset = imm_sext;
        p.wraddr = rt;     // immediates write rt
        p.wreg   = 1'b1;
        case (opcode)
            op_special: begin
                p.wraddr = rd;
                case (funct)
                    fn_addu: p.alu_op = alu_add;
                    fn_subu: p.alu_op = alu_sub;
                    fn_and:  p.alu_op = alu_and;
                    fn_or:   p.alu_op = alu_or;
                    fn_xor:  p.alu_op = alu_xor;
                    fn_slt:  p.alu_op = alu_slt;
                    fn_sll: begin
                        p.alu_op = alu_sll;
                        p.opr1   = src_t;
                        p.opr2   = data_w'(shamt);
                    end
                    default: known = 1'b0;
                endcase
            end
            op_addiu: begin
                p.alu_op = alu_add;
                p.opr2   = imm_sext;
            end
            op_ori: begin
                p.alu_op = alu_or;
                p.opr2   = imm_zext;
            end
            op_lui: begin
                p.alu_op = alu_lui;
                p.opr2   = imm_zext;
            end
            op_beq: begin
                p.br_kind = br_beq;
                p.wreg    = 1'b0;
            end
            op_bne: begin
                p.br_kind = br_bne;
                p.wreg    = 1'b0;
            end
            op_j: begin
                p.br_kind = br_j;
                p.wreg    = 1'b0;
                p.offset  = data_w'(id_instr[25:0]);
            end
            default: known = 1'b0;
        endcase
        id_ex = (id_valid && known) ? p : id_ex_bubble;
    end

endmodule

//--- verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t bubble    = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= bubble;
        end else begin
            case ({flush, stall})
                2'b10, 2'b11: q <= bubble;  // flush beats stall
                2'b00:        q <= d;
                default:      q <= q;
            endcase
        end
    end

endmodule

//--- verilog/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  pipe_pkg::id_ex_t               ex,
    input  logic                           wb_valid,
    input  logic                           commit_ready,
    output pipe_pkg::ex_wb_t               ex_wb,
    output logic                           fwd_wreg,
    output logic [isa_pkg::reg_addr_w-1:0] fwd_wraddr,
    output logic [isa_pkg::data_w-1:0]     fwd_data,
    output logic                           stall,
    output logic                           redirect,
    output logic [isa_pkg::data_w-1:0]     redirect_pc
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [data_w-1:0] result;
    logic [data_w-1:0] pc_plus4;
    logic [data_w-1:0] br_target;
    logic [data_w-1:0] j_target;
    logic              taken;

    always_comb begin
        case (ex.alu_op)
            alu_add: result = ex.opr1 + ex.opr2;
            alu_sub: result = ex.opr1 - ex.opr2;
            alu_and: result = ex.opr1 & ex.opr2;
            alu_or:  result = ex.opr1 | ex.opr2;
            alu_xor: result = ex.opr1 ^ ex.opr2;
            alu_slt: result = data_w'($signed(ex.opr1) < $signed(ex.opr2));
            alu_sll: result = ex.opr1 << ex.opr2[4:0];
            alu_lui: result = {ex.opr2[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    assign pc_plus4  = ex.pc + data_w'(4);
    assign br_target = pc_plus4 + {ex.offset[data_w-3:0], 2'b00};
    assign j_target  = {pc_plus4[data_w-1:28], ex.offset[25:0], 2'b00};

    always_comb begin
        case (ex.br_kind)
            br_beq:  taken = (ex.opr1 == ex.opr2);
            br_bne:  taken = (ex.opr1 != ex.opr2);
            br_j:    taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // commit port back-pressure freezes everything behind it
    assign stall       = wb_valid && !commit_ready;
    assign redirect    = ex.valid && taken && !stall;
    assign redirect_pc = (ex.br_kind == br_j) ? j_target : br_target;

    assign fwd_wreg   = ex.valid && ex.wreg;
    assign fwd_wraddr = ex.wraddr;
    assign fwd_data   = result;

    assign ex_wb = '{
        valid:  ex.valid,
        pc:     ex.pc,
        result: result,
        wraddr: ex.wraddr,
        wreg:   ex.valid && ex.wreg
    };

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter logic [isa_pkg::data_w-1:0] reset_pc = '0
) (
    input  logic                           clk,
    input  logic                           rst,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic [isa_pkg::data_w-3:0]     wb_adr,
    input  logic [isa_pkg::data_w-1:0]     wb_dat_i,
    input  logic                           wb_ack,
    input  logic                           commit_ready,
    output logic                           commit_valid,
    output logic [isa_pkg::data_w-1:0]     commit_pc,
    output logic [isa_pkg::reg_addr_w-1:0] commit_wraddr,
    output logic                           commit_wreg,
    output logic [isa_pkg::data_w-1:0]     commit_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                  stall;
    logic                  redirect;
    logic [data_w-1:0]     redirect_pc;
    logic                  id_valid;
    logic [data_w-1:0]     id_pc;
    logic [data_w-1:0]     id_instr;
    logic [reg_addr_w-1:0] ra1;
    logic [reg_addr_w-1:0] ra2;
    logic [data_w-1:0]     rd1;
    logic [data_w-1:0]     rd2;
    logic                  fwd_wreg;
    logic [reg_addr_w-1:0] fwd_wraddr;
    logic [data_w-1:0]     fwd_data;
    id_ex_t                id_ex_d;
    id_ex_t                id_ex_q;
    ex_wb_t                ex_wb_d;
    ex_wb_t                ex_wb_q;

    fetch_wb #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk), .rst(rst), .stall(stall),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .id_valid(id_valid), .id_pc(id_pc), .id_instr(id_instr)
    );

    decode u_decode (
        .id_valid(id_valid), .id_pc(id_pc), .id_instr(id_instr),
        .rd1(rd1), .rd2(rd2),
        .fwd_wreg(fwd_wreg), .fwd_wraddr(fwd_wraddr), .fwd_data(fwd_data),
        .ra1(ra1), .ra2(ra2), .id_ex(id_ex_d)
    );

    // written back from the EX/WB output, held there while commit stalls
    reg_file u_rf (
        .clk(clk), .rst(rst), .ra1(ra1), .ra2(ra2),
        .we(ex_wb_q.valid && ex_wb_q.wreg), .wa(ex_wb_q.wraddr), .wd(ex_wb_q.result),
        .rd1(rd1), .rd2(rd2)
    );

    pipe_reg #(.payload_t(id_ex_t), .bubble(id_ex_bubble)) u_id_ex (
        .clk(clk), .rst(rst), .stall(stall), .flush(redirect),
        .d(id_ex_d), .q(id_ex_q)
    );

    exec_stage u_exec (
        .ex(id_ex_q), .wb_valid(ex_wb_q.valid), .commit_ready(commit_ready),
        .ex_wb(ex_wb_d),
        .fwd_wreg(fwd_wreg), .fwd_wraddr(fwd_wraddr), .fwd_data(fwd_data),
        .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc)
    );

    pipe_reg #(.payload_t(ex_wb_t), .bubble(ex_wb_bubble)) u_ex_wb (
        .clk(clk), .rst(rst), .stall(stall), .flush(1'b0),  // squash happens only at ID/EX
        .d(ex_wb_d), .q(ex_wb_q)
    );

    assign commit_valid  = ex_wb_q.valid;
    assign commit_pc     = ex_wb_q.pc;
    assign commit_wraddr = ex_wb_q.wraddr;
    assign commit_wreg   = ex_wb_q.wreg;
    assign commit_data   = ex_wb_q.result;

endmodule

//--- bench/tb_model.svh
// included inside tb_core, which declares mem, seed and reset_pc before it

logic [31:0] model_regs [0:31];
logic [31:0] model_pc;

function automatic int rand_below(int n);
    return {$random(seed)} % n;
endfunction

// small register pool so that neighbours depend on each other often
function automatic logic [4:0] pick_reg();
    return 5'(rand_below(8));
endfunction

function automatic logic [31:0] enc_r(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                      logic [4:0] rd, logic [4:0] sh);
    return {op_special, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                      logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] random_instr(int i, int limit);
    int         kind;
    int         target;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    kind   = rand_below(16);
    rs     = pick_reg();
    rt     = pick_reg();
    rd     = pick_reg();
    target = i + 1 + rand_below(6);  // forward only, clipped to the block
    if (target > limit)
        target = limit;
    case (kind)
        0:       return enc_r(fn_addu, rs, rt, rd, 5'd0);
        1:       return enc_r(fn_subu, rs, rt, rd, 5'd0);
        2:       return enc_r(fn_and, rs, rt, rd, 5'd0);
        3:       return enc_r(fn_or, rs, rt, rd, 5'd0);
        4:       return enc_r(fn_xor, rs, rt, rd, 5'd0);
        5, 6:    return enc_r(fn_slt, rs, rt, rd, 5'd0);
        7:       return enc_r(fn_sll, 5'd0, rt, rd, 5'(rand_below(32)));
        10:      return enc_i(op_ori, rs, rt, 16'($random(seed)));
        11:      return enc_i(op_lui, 5'd0, rt, 16'($random(seed)));
        12:      return enc_i(op_beq, rs, rt, 16'(target - (i + 1)));
        13:      return enc_i(op_bne, rs, rt, 16'(target - (i + 1)));
        14:      return {op_j, 26'(target)};
        default: return enc_i(op_addiu, rs, rt, 16'($random(seed)));
    endcase
endfunction

// 16 blocks of 16 words; a loop block counts r30 down from 1..3 and branches back
task automatic fill_program();
    logic looped;
    int   base;
    int   limit;
    for (int b = 0; b < mem_words / 16; b++) begin
        base   = b * 16;
        looped = (b < mem_words / 16 - 1) && (rand_below(3) == 0);
        if (looped)
            limit = base + 14;  // never skip the decrement of the counter
        else if (base + 16 >= mem_words)
            limit = mem_words - 1;
        else
            limit = base + 16;
        for (int i = base; i < base + 16; i++) begin
            if (looped && i == base)
                mem[i] = enc_i(op_ori, 5'd0, 5'd30, 16'(1 + rand_below(3)));
            else if (looped && i == base + 14)
                mem[i] = enc_i(op_addiu, 5'd30, 5'd30, 16'hffff);
            else if (looped && i == base + 15)
                mem[i] = enc_i(op_bne, 5'd30, 5'd0, 16'(base + 1 + rand_below(4) - (i + 1)));
            else if (i == mem_words - 1)
                mem[i] = {op_j, 26'(i)};  // final self-jump
            else
                mem[i] = random_instr(i, limit);
        end
    end
endtask

task automatic reset_model();
    for (int r = 0; r < 32; r++)
        model_regs[r] = '0;
    model_pc = reset_pc;
endtask

// executes one instruction in program order and returns what it should retire as
task automatic model_step(output logic [31:0] pc, output logic [4:0] wraddr,
                          output logic wreg, output logic [31:0] data);
    logic [31:0] ins;
    logic [31:0] s;
    logic [31:0] t;
    logic [31:0] sext;
    logic [31:0] next_pc;
    ins     = mem[model_pc[9:2]];
    s       = model_regs[ins[25:21]];
    t       = model_regs[ins[20:16]];
    sext    = {{16{ins[15]}}, ins[15:0]};
    pc      = model_pc;
    next_pc = model_pc + 32'd4;
    wraddr  = ins[20:16];
    wreg    = 1'b1;
    data    = '0;
    case (ins[31:26])
        op_special: begin
            wraddr = ins[15:11];
            case (ins[5:0])
                fn_addu: data = s + t;
                fn_subu: data = s - t;
                fn_and:  data = s & t;
                fn_or:   data = s | t;
                fn_xor:  data = s ^ t;
                fn_slt:  data = {31'b0, $signed(s) < $signed(t)};
                default: data = t << ins[10:6];
            endcase
        end
        op_addiu: data = s + sext;
        op_ori:   data = s | {16'h0000, ins[15:0]};
        op_lui:   data = {ins[15:0], 16'h0000};
        op_j: begin
            wreg    = 1'b0;
            next_pc = {next_pc[31:28], ins[25:0], 2'b00};
        end
        default: begin
            wreg = 1'b0;
            if ((ins[31:26] == op_beq) == (s == t))
                next_pc = model_pc + 32'd4 + (sext << 2);
        end
    endcase
    if (wreg && wraddr != 5'd0)
        model_regs[wraddr] = data;  // r0 keeps reading as zero
    model_pc = next_pc;
endtask

//--- bench/tb_core.sv
`timescale 1ns/1ps

module tb_core;
    import isa_pkg::*;

    localparam logic [31:0] reset_pc    = 32'h0000_0040;  // start of the second block
    localparam int          mem_words   = 256;
    localparam logic [31:0] end_pc      = 32'((mem_words - 1) * 4);
    localparam int          wait_limit  = 200;   // cycles allowed for one commit
    localparam int          max_commits = 4000;
    localparam int          end_repeats = 3;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [data_w-3:0]     wb_adr;
    logic [data_w-1:0]     wb_dat_i;
    logic                  wb_ack;
    logic                  commit_ready;
    logic                  commit_valid;
    logic [data_w-1:0]     commit_pc;
    logic [reg_addr_w-1:0] commit_wraddr;
    logic                  commit_wreg;
    logic [data_w-1:0]     commit_data;

    integer                seed = 32'hd9cb_9e94;
    logic [31:0]           mem [0:mem_words-1];
    int                    wait_left;
    int                    errors;

    `include "tb_model.svh"

    core_top #(.reset_pc(reset_pc)) uut (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .commit_ready(commit_ready), .commit_valid(commit_valid),
        .commit_pc(commit_pc), .commit_wraddr(commit_wraddr),
        .commit_wreg(commit_wreg), .commit_data(commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Wishbone slave with 0 to 3 wait states, plus random commit back-pressure
    initial begin
        commit_ready = 1'b0;
        wb_ack       = 1'b0;
        wb_dat_i     = '0;
        wait_left    = 0;
        forever begin
            @(posedge clk);
            #1;
            commit_ready = ({$random(seed)} % 4) != 0;
            if (wb_ack) begin
                wb_ack = 1'b0;  // one ack per cycle, master drops cyc now
            end else if (wb_cyc && wb_stb && !rst) begin
                if (wait_left == 0) begin
                    wb_ack    = 1'b1;
                    wb_dat_i  = mem[wb_adr[7:0]];
                    wait_left = {$random(seed)} % 4;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic fail_now();
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, expected);
            fail_now();
        end
    endtask

    // every cycle the commit port is valid it must show the next expected item
    task automatic wait_commit(input logic [31:0] pc, input logic [4:0] wraddr,
                               input logic wreg, input logic [31:0] data);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (commit_valid) begin
                check_value("commit_pc", commit_pc, pc);
                check_value("commit_wreg", {31'b0, commit_wreg}, {31'b0, wreg});
                if (wreg) begin
                    check_value("commit_wraddr", {27'b0, commit_wraddr}, {27'b0, wraddr});
                    check_value("commit_data", commit_data, data);
                end
                done = commit_ready;
            end
            cycles++;
            if (!done && cycles >= wait_limit) begin
                $display("timeout: instruction at pc %h did not retire in %0d cycles",
                         pc, wait_limit);
                fail_now();
            end
        end
    endtask

    initial begin
        logic [31:0] exp_pc;
        logic [4:0]  exp_wraddr;
        logic        exp_wreg;
        logic [31:0] exp_data;
        int          cycles;
        int          end_hits;
        int          n_commits;
        rst    = 1'b1;
        errors = 0;
        fill_program();
        reset_model();

        @(posedge clk);
        #1;
        check_value("wb_cyc during reset", {31'b0, wb_cyc}, 32'd0);
        check_value("commit_valid during reset", {31'b0, commit_valid}, 32'd0);
        @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_value("wb_cyc after reset", {31'b0, wb_cyc}, 32'd0);
        check_value("commit_valid after reset", {31'b0, commit_valid}, 32'd0);

        cycles = 0;
        while (!wb_cyc) begin
            @(negedge clk);
            cycles++;
            if (!wb_cyc && cycles >= 10) begin
                $display("timeout: no Wishbone cycle started after reset");
                fail_now();
            end
        end
        check_value("first wb_adr", {2'b00, wb_adr}, {2'b00, reset_pc[31:2]});

        end_hits  = 0;
        n_commits = 0;
        while (end_hits < end_repeats) begin
            model_step(exp_pc, exp_wraddr, exp_wreg, exp_data);
            if (exp_pc == end_pc)
                end_hits++;
            wait_commit(exp_pc, exp_wraddr, exp_wreg, exp_data);
            n_commits++;
            if (n_commits > max_commits) begin
                $display("program did not reach its final self-jump within %0d commits",
                         max_commits);
                fail_now();
            end
        end

        if (errors == 0) begin
            $display("%0d instructions retired in program order", n_commits);
            $display("No errors");
            $finish;
        end else begin
            fail_now();
        end
    end

endmodule

//--- all.f
+incdir+bench
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_wb.sv
verilog/reg_file.sv
verilog/decode.sv
verilog/pipe_reg.sv
verilog/exec_stage.sv
verilog/core_top.sv
bench/tb_core.sv
